//--- rtl/eth_dma_pkg.sv
package eth_dma_pkg;

  // External memory bus
  localparam int AXI_ADDR_W        = 32;
  localparam int AXI_DATA_W        = 32;
  localparam int AXI_LEN_W         = 8;
  localparam int AXI_MAX_BURST_LEN = 16;

  // Frame buffers
  localparam int BUFFER_W    = 11;
  localparam int FRAME_LEN_W = 11;

  // Descriptor memory, status and pointer word per descriptor
  localparam int BD_ADDR_W = 8;
  localparam int BD_NUM_W  = BD_ADDR_W - 1;
  localparam int BD_W      = 32;

  // Status word fields
  localparam int BD_READY_BIT   = 15;
  localparam int BD_IRQ_BIT     = 14;
  localparam int BD_WRAP_BIT    = 13;
  localparam int BD_CRC_EN_BIT  = 11;
  localparam int BD_CRC_ERR_BIT = 1;
  localparam int BD_LEN_LSB     = 16;
  localparam int BD_LEN_MSB     = 31;

  // Ethernet framing ahead of the first frame byte
  localparam int         PREAMBLE_LEN  = 7;
  localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0] SFD_BYTE      = 8'hD5;
  localparam int         PRE_FRAME_LEN = PREAMBLE_LEN + 1;

  typedef logic [BD_W-1:0]        bd_word_t;
  typedef logic [BD_NUM_W-1:0]    bd_num_t;
  typedef logic [FRAME_LEN_W-1:0] frame_len_t;
  typedef logic [BUFFER_W-1:0]    buf_addr_t;

endpackage

//--- rtl/bd_arbiter.sv
`timescale 1ns/1ps

module bd_arbiter (
  input  logic clk_i,
  input  logic arst_i,
  input  logic tx_req_i,
  input  logic rx_req_i,
  output logic tx_gnt_o,
  output logic rx_gnt_o
);

  // Set when the receive engine was the last one served
  logic rx_last;

  // Under contention the engine not served last wins
  assign tx_gnt_o = tx_req_i & (~rx_req_i | rx_last);
  assign rx_gnt_o = rx_req_i & (~tx_req_i | ~rx_last);

  always_ff @(posedge clk_i) begin
    if (arst_i) begin
      rx_last <= 1'b1;
    end else if (tx_gnt_o) begin
      rx_last <= 1'b0;
    end else if (rx_gnt_o) begin
      rx_last <= 1'b1;
    end
  end

endmodule

//--- rtl/tx_dma.sv
`timescale 1ns/1ps

module tx_dma (
  input  logic                                  clk_i,
  input  logic                                  arst_i,
  input  logic                                  tx_en_i,
  output logic                                  bd_req_o,
  input  logic                                  bd_gnt_i,
  output logic [eth_dma_pkg::BD_ADDR_W-1:0]     bd_addr_o,
  output logic                                  bd_wen_o,
  output eth_dma_pkg::bd_word_t                 bd_wdata_o,
  input  eth_dma_pkg::bd_word_t                 bd_rdata_i,
  output logic                                  buf_wen_o,
  output eth_dma_pkg::buf_addr_t                buf_addr_o,
  output logic [7:0]                            buf_wdata_o,
  input  logic                                  tx_ready_i,
  output logic                                  send_o,
  output logic                                  crc_en_o,
  output eth_dma_pkg::frame_len_t               tx_nbytes_o,
  output logic [eth_dma_pkg::AXI_ADDR_W-1:0]    araddr_o,
  output logic [eth_dma_pkg::AXI_LEN_W-1:0]     arlen_o,
  output logic                                  arvalid_o,
  input  logic                                  arready_i,
  input  logic [eth_dma_pkg::AXI_DATA_W-1:0]    rdata_i,
  input  logic                                  rvalid_i,
  input  logic                                  rlast_i,
  output logic                                  rready_o,
  output logic                                  tx_irq_o
);

  import eth_dma_pkg::*;

  typedef enum logic [3:0] {
    S_PRE,
    S_BD_REQ,
    S_BD_RD,
    S_PTR_REQ,
    S_PTR_RD,
    S_TX_WAIT,
    S_AR,
    S_R,
    S_SEND,
    S_WB
  } tx_state_t;

  tx_state_t             state;
  bd_num_t               bd_num;
  bd_word_t              desc;
  logic [AXI_ADDR_W-1:0] ptr;
  frame_len_t            byte_cnt;
  frame_len_t            frame_len;
  frame_len_t            remaining;
  logic [AXI_ADDR_W-1:0] rd_addr;

  assign frame_len = desc[BD_LEN_LSB +: FRAME_LEN_W];
  assign remaining = frame_len - byte_cnt;
  assign rd_addr   = ptr + AXI_ADDR_W'(byte_cnt);

  // Bursts are capped at the AXI limit, single byte per beat
  assign araddr_o = rd_addr;
  assign arlen_o  = (remaining > AXI_MAX_BURST_LEN) ? AXI_LEN_W'(AXI_MAX_BURST_LEN - 1)
                                                    : AXI_LEN_W'(remaining - 1'b1);

  always_comb begin
    bd_req_o    = 1'b0;
    bd_addr_o   = {bd_num, 1'b0};
    bd_wen_o    = 1'b0;
    bd_wdata_o  = desc;
    buf_wen_o   = 1'b0;
    buf_addr_o  = buf_addr_t'(PRE_FRAME_LEN) + buf_addr_t'(byte_cnt);
    buf_wdata_o = rdata_i[{rd_addr[1:0], 3'b000} +: 8];
    arvalid_o   = 1'b0;
    rready_o    = 1'b0;
    tx_irq_o    = 1'b0;
    case (state)
      S_PRE: begin
        buf_wen_o   = 1'b1;
        buf_addr_o  = buf_addr_t'(byte_cnt);
        buf_wdata_o = (byte_cnt == PREAMBLE_LEN) ? SFD_BYTE : PREAMBLE_BYTE;
      end
      S_BD_REQ: bd_req_o = 1'b1;
      S_PTR_REQ: begin
        bd_req_o  = 1'b1;
        bd_addr_o = {bd_num, 1'b1};
      end
      S_AR: arvalid_o = (remaining != '0);
      S_R: begin
        rready_o  = 1'b1;
        buf_wen_o = rvalid_i;
      end
      S_WB: begin
        bd_req_o = 1'b1;
        bd_wen_o = 1'b1;
        tx_irq_o = bd_gnt_i & desc[BD_IRQ_BIT];
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (arst_i) begin
      state    <= S_PRE;
      bd_num   <= '0;
      byte_cnt <= '0;
      send_o   <= 1'b0;
    end else begin
      case (state)
        // Preamble and SFD go in once, then the buffer keeps them
        S_PRE: begin
          byte_cnt <= byte_cnt + 1'b1;
          if (byte_cnt == frame_len_t'(PRE_FRAME_LEN - 1)) state <= S_BD_REQ;
        end
        S_BD_REQ: if (bd_gnt_i) state <= S_BD_RD;
        S_BD_RD: begin
          if (bd_rdata_i[BD_READY_BIT] && tx_en_i) state <= S_PTR_REQ;
          else state <= S_BD_REQ;
        end
        S_PTR_REQ: if (bd_gnt_i) state <= S_PTR_RD;
        S_PTR_RD: begin
          byte_cnt <= '0;
          state    <= S_TX_WAIT;
        end
        S_TX_WAIT: if (tx_ready_i) state <= S_AR;
        S_AR: begin
          if (remaining == '0) begin
            send_o <= 1'b1;
            state  <= S_SEND;
          end else if (arready_i) begin
            state <= S_R;
          end
        end
        S_R: begin
          if (rvalid_i) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (rlast_i) state <= S_AR;
          end
        end
        // Transmitter drops ready once it has taken the frame
        S_SEND: begin
          if (!tx_ready_i) begin
            send_o <= 1'b0;
            state  <= S_WB;
          end
        end
        S_WB: begin
          if (bd_gnt_i) begin
            state <= S_BD_REQ;
            if (desc[BD_WRAP_BIT] || &bd_num) bd_num <= '0;
            else bd_num <= bd_num + 1'b1;
          end
        end
        default: state <= S_BD_REQ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == S_BD_RD) desc <= bd_rdata_i;
    if (state == S_PTR_RD) ptr <= AXI_ADDR_W'(bd_rdata_i);
    if (state == S_AR && remaining == '0) begin
      desc[BD_READY_BIT] <= 1'b0;
      crc_en_o           <= desc[BD_CRC_EN_BIT];
      tx_nbytes_o        <= frame_len_t'(PRE_FRAME_LEN) + frame_len;
    end
  end

endmodule

//--- rtl/rx_dma.sv
`timescale 1ns/1ps

module rx_dma (
  input  logic                                  clk_i,
  input  logic                                  arst_i,
  input  logic                                  rx_en_i,
  input  eth_dma_pkg::bd_num_t                  tx_bd_num_i,
  output logic                                  bd_req_o,
  input  logic                                  bd_gnt_i,
  output logic [eth_dma_pkg::BD_ADDR_W-1:0]     bd_addr_o,
  output logic                                  bd_wen_o,
  output eth_dma_pkg::bd_word_t                 bd_wdata_o,
  input  eth_dma_pkg::bd_word_t                 bd_rdata_i,
  output eth_dma_pkg::buf_addr_t                buf_addr_o,
  input  logic [7:0]                            buf_rdata_i,
  input  logic                                  rx_data_rcvd_i,
  input  eth_dma_pkg::frame_len_t               rx_nbytes_i,
  input  logic                                  crc_err_i,
  output logic                                  rcv_ack_o,
  output logic [eth_dma_pkg::AXI_ADDR_W-1:0]    awaddr_o,
  output logic [eth_dma_pkg::AXI_LEN_W-1:0]     awlen_o,
  output logic                                  awvalid_o,
  input  logic                                  awready_i,
  output logic [eth_dma_pkg::AXI_DATA_W-1:0]    wdata_o,
  output logic [eth_dma_pkg::AXI_DATA_W/8-1:0]  wstrb_o,
  output logic                                  wvalid_o,
  output logic                                  wlast_o,
  input  logic                                  wready_i,
  input  logic                                  bvalid_i,
  output logic                                  bready_o,
  output logic                                  rx_irq_o
);

  import eth_dma_pkg::*;

  typedef enum logic [3:0] {
    S_BD_REQ,
    S_BD_RD,
    S_PTR_REQ,
    S_PTR_RD,
    S_RX_WAIT,
    S_AW,
    S_W,
    S_ACK,
    S_WB
  } rx_state_t;

  rx_state_t             state;
  bd_num_t               bd_num;
  bd_word_t              desc;
  logic [AXI_ADDR_W-1:0] ptr;
  frame_len_t            byte_cnt;
  frame_len_t            remaining;
  logic [AXI_ADDR_W-1:0] wr_addr;
  logic [AXI_LEN_W-1:0]  awlen_q;
  logic [AXI_LEN_W-1:0]  beat;

  assign remaining = rx_nbytes_i - byte_cnt;
  assign wr_addr   = ptr + AXI_ADDR_W'(byte_cnt);

  assign awaddr_o = wr_addr;
  assign awlen_o  = (remaining > AXI_MAX_BURST_LEN) ? AXI_LEN_W'(AXI_MAX_BURST_LEN - 1)
                                                    : AXI_LEN_W'(remaining - 1'b1);

  // One byte per beat, placed on its own lane
  assign wdata_o  = AXI_DATA_W'(buf_rdata_i) << {wr_addr[1:0], 3'b000};
  assign wstrb_o  = {{(AXI_DATA_W / 8 - 1){1'b0}}, 1'b1} << wr_addr[1:0];
  assign wlast_o  = (state == S_W) && (beat == awlen_q);

  // Write responses are not tracked
  assign bready_o = 1'b1;

  always_comb begin
    bd_req_o   = 1'b0;
    bd_addr_o  = {bd_num, 1'b0};
    bd_wen_o   = 1'b0;
    bd_wdata_o = desc;
    buf_addr_o = buf_addr_t'(byte_cnt);
    awvalid_o  = 1'b0;
    wvalid_o   = 1'b0;
    rx_irq_o   = 1'b0;
    case (state)
      S_BD_REQ: bd_req_o = 1'b1;
      S_PTR_REQ: begin
        bd_req_o  = 1'b1;
        bd_addr_o = {bd_num, 1'b1};
      end
      S_AW: awvalid_o = (remaining != '0);
      S_W: begin
        wvalid_o = 1'b1;
        // Fetch the next byte early so it is ready for the next beat
        if (wready_i) buf_addr_o = buf_addr_t'(byte_cnt + 1'b1);
      end
      S_WB: begin
        bd_req_o = 1'b1;
        bd_wen_o = 1'b1;
        rx_irq_o = bd_gnt_i & desc[BD_IRQ_BIT];
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (arst_i) begin
      state     <= S_BD_REQ;
      bd_num    <= tx_bd_num_i;
      byte_cnt  <= '0;
      beat      <= '0;
      rcv_ack_o <= 1'b0;
    end else begin
      case (state)
        S_BD_REQ: if (bd_gnt_i) state <= S_BD_RD;
        S_BD_RD: begin
          if (bd_rdata_i[BD_READY_BIT] && rx_en_i) state <= S_PTR_REQ;
          else state <= S_BD_REQ;
        end
        S_PTR_REQ: if (bd_gnt_i) state <= S_PTR_RD;
        S_PTR_RD: begin
          byte_cnt <= '0;
          state    <= S_RX_WAIT;
        end
        S_RX_WAIT: if (rx_data_rcvd_i) state <= S_AW;
        S_AW: begin
          beat <= '0;
          if (remaining == '0) begin
            rcv_ack_o <= 1'b1;
            state     <= S_ACK;
          end else if (awready_i) begin
            state <= S_W;
          end
        end
        S_W: begin
          if (wready_i) begin
            byte_cnt <= byte_cnt + 1'b1;
            beat     <= beat + 1'b1;
            if (beat == awlen_q) state <= S_AW;
          end
        end
        // Receiver releases the buffer by dropping its flag
        S_ACK: begin
          if (!rx_data_rcvd_i) begin
            rcv_ack_o <= 1'b0;
            state     <= S_WB;
          end
        end
        S_WB: begin
          if (bd_gnt_i) begin
            state <= S_BD_REQ;
            if (desc[BD_WRAP_BIT] || &bd_num) bd_num <= tx_bd_num_i;
            else bd_num <= bd_num + 1'b1;
          end
        end
        default: state <= S_BD_REQ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == S_BD_RD) desc <= bd_rdata_i;
    if (state == S_PTR_RD) ptr <= AXI_ADDR_W'(bd_rdata_i);
    if (state == S_AW) awlen_q <= awlen_o;
    // Status for write-back once the whole frame is out
    if (state == S_AW && remaining == '0) begin
      desc[BD_READY_BIT]              <= 1'b0;
      desc[BD_CRC_ERR_BIT]            <= crc_err_i;
      desc[BD_LEN_MSB:BD_LEN_LSB]     <= (BD_LEN_MSB - BD_LEN_LSB + 1)'(rx_nbytes_i);
    end
  end

endmodule

//--- rtl/eth_dma.sv
`timescale 1ns/1ps

module eth_dma (
  input  logic                                  clk_i,
  input  logic                                  arst_i,
  input  logic                                  tx_en_i,
  input  logic                                  rx_en_i,
  input  eth_dma_pkg::bd_num_t                  tx_bd_num_i,
  output logic [eth_dma_pkg::BD_ADDR_W-1:0]     bd_addr_o,
  output logic                                  bd_wen_o,
  output eth_dma_pkg::bd_word_t                 bd_o,
  input  eth_dma_pkg::bd_word_t                 bd_i,
  output logic                                  eth_data_wr_wen_o,
  output eth_dma_pkg::buf_addr_t                eth_data_wr_addr_o,
  output logic [7:0]                            eth_data_wr_wdata_o,
  input  logic                                  tx_ready_i,
  output logic                                  send_o,
  output logic                                  crc_en_o,
  output eth_dma_pkg::frame_len_t               tx_nbytes_o,
  output eth_dma_pkg::buf_addr_t                eth_data_rd_addr_o,
  input  logic [7:0]                            eth_data_rd_rdata_i,
  input  logic                                  rx_data_rcvd_i,
  input  eth_dma_pkg::frame_len_t               rx_nbytes_i,
  input  logic                                  crc_err_i,
  output logic                                  rcv_ack_o,
  output logic [eth_dma_pkg::AXI_ADDR_W-1:0]    axi_araddr_o,
  output logic [eth_dma_pkg::AXI_LEN_W-1:0]     axi_arlen_o,
  output logic                                  axi_arvalid_o,
  input  logic                                  axi_arready_i,
  input  logic [eth_dma_pkg::AXI_DATA_W-1:0]    axi_rdata_i,
  input  logic                                  axi_rvalid_i,
  input  logic                                  axi_rlast_i,
  output logic                                  axi_rready_o,
  output logic [eth_dma_pkg::AXI_ADDR_W-1:0]    axi_awaddr_o,
  output logic [eth_dma_pkg::AXI_LEN_W-1:0]     axi_awlen_o,
  output logic                                  axi_awvalid_o,
  input  logic                                  axi_awready_i,
  output logic [eth_dma_pkg::AXI_DATA_W-1:0]    axi_wdata_o,
  output logic [eth_dma_pkg::AXI_DATA_W/8-1:0]  axi_wstrb_o,
  output logic                                  axi_wvalid_o,
  output logic                                  axi_wlast_o,
  input  logic                                  axi_wready_i,
  input  logic                                  axi_bvalid_i,
  output logic                                  axi_bready_o,
  output logic                                  tx_irq_o,
  output logic                                  rx_irq_o
);

  import eth_dma_pkg::*;

  logic                 tx_req;
  logic                 rx_req;
  logic                 tx_gnt;
  logic                 rx_gnt;
  logic [BD_ADDR_W-1:0] tx_bd_addr;
  logic [BD_ADDR_W-1:0] rx_bd_addr;
  logic                 tx_bd_wen;
  logic                 rx_bd_wen;
  bd_word_t             tx_bd_wdata;
  bd_word_t             rx_bd_wdata;

  // Descriptor port follows the grant, writes only when granted
  assign bd_addr_o = rx_gnt ? rx_bd_addr : tx_bd_addr;
  assign bd_o      = rx_gnt ? rx_bd_wdata : tx_bd_wdata;
  assign bd_wen_o  = (tx_gnt & tx_bd_wen) | (rx_gnt & rx_bd_wen);

  bd_arbiter bd_arbiter_inst (
    .clk_i    (clk_i),
    .arst_i   (arst_i),
    .tx_req_i (tx_req),
    .rx_req_i (rx_req),
    .tx_gnt_o (tx_gnt),
    .rx_gnt_o (rx_gnt)
  );

  tx_dma tx_dma_inst (
    .clk_i       (clk_i),
    .arst_i      (arst_i),
    .tx_en_i     (tx_en_i),
    .bd_req_o    (tx_req),
    .bd_gnt_i    (tx_gnt),
    .bd_addr_o   (tx_bd_addr),
    .bd_wen_o    (tx_bd_wen),
    .bd_wdata_o  (tx_bd_wdata),
    .bd_rdata_i  (bd_i),
    .buf_wen_o   (eth_data_wr_wen_o),
    .buf_addr_o  (eth_data_wr_addr_o),
    .buf_wdata_o (eth_data_wr_wdata_o),
    .tx_ready_i  (tx_ready_i),
    .send_o      (send_o),
    .crc_en_o    (crc_en_o),
    .tx_nbytes_o (tx_nbytes_o),
    .araddr_o    (axi_araddr_o),
    .arlen_o     (axi_arlen_o),
    .arvalid_o   (axi_arvalid_o),
    .arready_i   (axi_arready_i),
    .rdata_i     (axi_rdata_i),
    .rvalid_i    (axi_rvalid_i),
    .rlast_i     (axi_rlast_i),
    .rready_o    (axi_rready_o),
    .tx_irq_o    (tx_irq_o)
  );

  rx_dma rx_dma_inst (
    .clk_i          (clk_i),
    .arst_i         (arst_i),
    .rx_en_i        (rx_en_i),
    .tx_bd_num_i    (tx_bd_num_i),
    .bd_req_o       (rx_req),
    .bd_gnt_i       (rx_gnt),
    .bd_addr_o      (rx_bd_addr),
    .bd_wen_o       (rx_bd_wen),
    .bd_wdata_o     (rx_bd_wdata),
    .bd_rdata_i     (bd_i),
    .buf_addr_o     (eth_data_rd_addr_o),
    .buf_rdata_i    (eth_data_rd_rdata_i),
    .rx_data_rcvd_i (rx_data_rcvd_i),
    .rx_nbytes_i    (rx_nbytes_i),
    .crc_err_i      (crc_err_i),
    .rcv_ack_o      (rcv_ack_o),
    .awaddr_o       (axi_awaddr_o),
    .awlen_o        (axi_awlen_o),
    .awvalid_o      (axi_awvalid_o),
    .awready_i      (axi_awready_i),
    .wdata_o        (axi_wdata_o),
    .wstrb_o        (axi_wstrb_o),
    .wvalid_o       (axi_wvalid_o),
    .wlast_o        (axi_wlast_o),
    .wready_i       (axi_wready_i),
    .bvalid_i       (axi_bvalid_i),
    .bready_o       (axi_bready_o),
    .rx_irq_o       (rx_irq_o)
  );

endmodule

//--- test/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
  input  logic                                  clk_i,
  input  logic                                  arst_i,
  input  logic [eth_dma_pkg::AXI_ADDR_W-1:0]    araddr_i,
  input  logic [eth_dma_pkg::AXI_LEN_W-1:0]     arlen_i,
  input  logic                                  arvalid_i,
  output logic                                  arready_o,
  output logic [eth_dma_pkg::AXI_DATA_W-1:0]    rdata_o,
  output logic                                  rvalid_o,
  output logic                                  rlast_o,
  input  logic                                  rready_i,
  input  logic [eth_dma_pkg::AXI_ADDR_W-1:0]    awaddr_i,
  input  logic                                  awvalid_i,
  output logic                                  awready_o,
  input  logic [eth_dma_pkg::AXI_DATA_W-1:0]    wdata_i,
  input  logic [eth_dma_pkg::AXI_DATA_W/8-1:0]  wstrb_i,
  input  logic                                  wvalid_i,
  input  logic                                  wlast_i,
  output logic                                  wready_o,
  output logic                                  bvalid_o,
  input  logic [eth_dma_pkg::BD_ADDR_W-1:0]     bd_addr_i,
  input  logic                                  bd_wen_i,
  input  eth_dma_pkg::bd_word_t                 bd_wdata_i,
  output eth_dma_pkg::bd_word_t                 bd_rdata_o,
  input  logic                                  txb_wen_i,
  input  eth_dma_pkg::buf_addr_t                txb_addr_i,
  input  logic [7:0]                            txb_wdata_i,
  input  eth_dma_pkg::buf_addr_t                rxb_addr_i,
  output logic [7:0]                            rxb_rdata_o
);

  import eth_dma_pkg::*;

  logic [7:0]  ext_mem [0:4095];
  bd_word_t    bd_mem [0:255];
  logic [7:0]  tx_buf [0:2047];
  logic [7:0]  rx_buf [0:2047];
  int          seed;
  logic [31:0] rnd;
  logic        rd_busy;
  logic [11:0] rd_addr;
  logic [7:0]  rd_left;
  logic        wr_busy;
  logic [11:0] wr_addr;

  initial begin
    seed = 32'h9ff74d9e;
    arready_o = 1'b0;
    rvalid_o = 1'b0;
    rlast_o = 1'b0;
    rdata_o = '0;
    awready_o = 1'b0;
    wready_o = 1'b0;
    bvalid_o = 1'b0;
    bd_rdata_o = '0;
    rxb_rdata_o = '0;
    // Fill pattern mixes all address bits
    for (int i = 0; i < 4096; i++) ext_mem[i] = 8'((i * 29) ^ (i >> 7));
    for (int i = 0; i < 2048; i++) rx_buf[i] = 8'($random(seed));
  end

  // Burst slave with random stalls on every channel
  always @(posedge clk_i) begin
    rnd = $random(seed);
    if (arst_i) begin
      arready_o <= 1'b0;
      rvalid_o <= 1'b0;
      rlast_o <= 1'b0;
      awready_o <= 1'b0;
      wready_o <= 1'b0;
      bvalid_o <= 1'b0;
      rd_busy <= 1'b0;
      wr_busy <= 1'b0;
    end else begin
      bvalid_o <= 1'b0;
      if (!rd_busy) begin
        rvalid_o <= 1'b0;
        rlast_o <= 1'b0;
        if (arvalid_i && arready_o) begin
          rd_busy <= 1'b1;
          rd_addr <= araddr_i[11:0];
          rd_left <= arlen_i;
          arready_o <= 1'b0;
        end else begin
          arready_o <= rnd[0];
        end
      end else if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
        rlast_o <= 1'b0;
        if (rlast_o) rd_busy <= 1'b0;
        rd_addr <= rd_addr + 1'b1;
        rd_left <= rd_left - 1'b1;
      end else if (!rvalid_o && rnd[2:1] != 2'b00) begin
        rvalid_o <= 1'b1;
        rlast_o <= (rd_left == 8'd0);
        rdata_o <= {ext_mem[{rd_addr[11:2], 2'd3}], ext_mem[{rd_addr[11:2], 2'd2}],
                    ext_mem[{rd_addr[11:2], 2'd1}], ext_mem[{rd_addr[11:2], 2'd0}]};
      end
      if (!wr_busy) begin
        wready_o <= 1'b0;
        if (awvalid_i && awready_o) begin
          wr_busy <= 1'b1;
          wr_addr <= awaddr_i[11:0];
          awready_o <= 1'b0;
        end else begin
          awready_o <= rnd[3];
        end
      end else begin
        wready_o <= (rnd[5:4] != 2'b00);
        if (wvalid_i && wready_o) begin
          for (int k = 0; k < 4; k++) begin
            if (wstrb_i[k]) ext_mem[{wr_addr[11:2], 2'(k)}] <= wdata_i[8*k +: 8];
          end
          wr_addr <= wr_addr + 1'b1;
          if (wlast_i) begin
            wr_busy <= 1'b0;
            wready_o <= 1'b0;
            bvalid_o <= 1'b1;
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    bd_rdata_o <= bd_mem[bd_addr_i];
    if (bd_wen_i) bd_mem[bd_addr_i] <= bd_wdata_i;
    if (txb_wen_i) tx_buf[txb_addr_i] <= txb_wdata_i;
    rxb_rdata_o <= rx_buf[rxb_addr_i];
  end

endmodule

//--- test/tb_eth_dma.sv
`timescale 1ns/1ps

module tb_eth_dma;

  import eth_dma_pkg::*;

  localparam int TIMEOUT = 4000;
  localparam int RX_IDX  = 8;

  logic        clk_i;
  logic        arst_i;
  logic        tx_en_i;
  logic        rx_en_i;
  bd_num_t     tx_bd_num_i;
  logic        tx_ready_i;
  logic        rx_data_rcvd_i;
  frame_len_t  rx_nbytes_i;
  logic        crc_err_i;
  logic [BD_ADDR_W-1:0] bd_addr_o;
  logic        bd_wen_o;
  bd_word_t    bd_o;
  bd_word_t    bd_i;
  logic        eth_data_wr_wen_o;
  buf_addr_t   eth_data_wr_addr_o;
  logic [7:0]  eth_data_wr_wdata_o;
  logic        send_o;
  logic        crc_en_o;
  frame_len_t  tx_nbytes_o;
  buf_addr_t   eth_data_rd_addr_o;
  logic [7:0]  eth_data_rd_rdata_i;
  logic        rcv_ack_o;
  logic [31:0] axi_araddr_o;
  logic [7:0]  axi_arlen_o;
  logic        axi_arvalid_o;
  logic        axi_arready_i;
  logic [31:0] axi_rdata_i;
  logic        axi_rvalid_i;
  logic        axi_rlast_i;
  logic        axi_rready_o;
  logic [31:0] axi_awaddr_o;
  logic [7:0]  axi_awlen_o;
  logic        axi_awvalid_o;
  logic        axi_awready_i;
  logic [31:0] axi_wdata_o;
  logic [3:0]  axi_wstrb_o;
  logic        axi_wvalid_o;
  logic        axi_wlast_o;
  logic        axi_wready_i;
  logic        axi_bvalid_i;
  logic        axi_bready_o;
  logic        tx_irq_o;
  logic        rx_irq_o;

  int          seed;
  int          error_count;
  int          tx_wb_cnt;
  int          rx_wb_cnt;
  int          tx_irq_cnt;
  int          rx_irq_cnt;
  logic [31:0] aw_cur;
  logic [7:0]  aw_len;
  int          beat_n;
  logic        rx_served_last;
  logic        served_any;

  eth_dma eth_dma_inst (.*);

  tb_mem_model tb_mem_model_inst (
    .clk_i (clk_i), .arst_i (arst_i),
    .araddr_i (axi_araddr_o), .arlen_i (axi_arlen_o), .arvalid_i (axi_arvalid_o),
    .arready_o (axi_arready_i), .rdata_o (axi_rdata_i), .rvalid_o (axi_rvalid_i),
    .rlast_o (axi_rlast_i), .rready_i (axi_rready_o),
    .awaddr_i (axi_awaddr_o), .awvalid_i (axi_awvalid_o), .awready_o (axi_awready_i),
    .wdata_i (axi_wdata_o), .wstrb_i (axi_wstrb_o), .wvalid_i (axi_wvalid_o),
    .wlast_i (axi_wlast_o), .wready_o (axi_wready_i), .bvalid_o (axi_bvalid_i),
    .bd_addr_i (bd_addr_o), .bd_wen_i (bd_wen_o), .bd_wdata_i (bd_o), .bd_rdata_o (bd_i),
    .txb_wen_i (eth_data_wr_wen_o), .txb_addr_i (eth_data_wr_addr_o),
    .txb_wdata_i (eth_data_wr_wdata_o),
    .rxb_addr_i (eth_data_rd_addr_o), .rxb_rdata_o (eth_data_rd_rdata_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string msg);
    error_count++;
    $display("mismatch at %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string msg);
    error_count++;
    $display("Timed out at %0t waiting for %s", $time, msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  function automatic bd_word_t make_status(int len, bit irq, bit wrap, bit crc_en);
    bd_word_t w;
    w = '0;
    w[BD_LEN_MSB:BD_LEN_LSB] = 16'(len);
    w[BD_READY_BIT] = 1'b1;
    w[BD_IRQ_BIT] = irq;
    w[BD_WRAP_BIT] = wrap;
    w[BD_CRC_EN_BIT] = crc_en;
    return w;
  endfunction

  task automatic load_descriptor(input int idx, input bd_word_t status, input bd_word_t ptr);
    @(negedge clk_i);
    tb_mem_model_inst.bd_mem[2*idx] = status;
    tb_mem_model_inst.bd_mem[2*idx+1] = ptr;
  endtask

  task automatic wait_for_send();
    int n;
    n = 0;
    while (!send_o) begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) report_timeout("send_o");
    end
  endtask

  task automatic wait_for_ack();
    int n;
    n = 0;
    while (!rcv_ack_o) begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) report_timeout("rcv_ack_o");
    end
  endtask

  task automatic wait_for_writeback(input bit is_rx, input int target);
    int n;
    n = 0;
    while ((is_rx ? rx_wb_cnt : tx_wb_cnt) < target) begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) report_timeout("descriptor write-back");
    end
  endtask

  // One transmit frame from send to status write-back
  task automatic check_tx_frame(input int idx, input int len, input int ptr,
                                input bd_word_t status, input int wb_target);
    bd_word_t exp;
    wait_for_send();
    for (int i = 0; i < len; i++) begin
      assert (tb_mem_model_inst.tx_buf[PRE_FRAME_LEN + i] ==
              tb_mem_model_inst.ext_mem[(ptr + i) % 4096])
        else report_mismatch($sformatf("tx buffer byte %0d of frame at index %0d", i, idx));
    end
    assert (tx_nbytes_o == frame_len_t'(PRE_FRAME_LEN + len))
      else report_mismatch("tx_nbytes_o");
    assert (crc_en_o == status[BD_CRC_EN_BIT]) else report_mismatch("crc_en_o");
    @(posedge clk_i);
    tx_ready_i <= 1'b0;
    wait_for_writeback(1'b0, wb_target);
    exp = status;
    exp[BD_READY_BIT] = 1'b0;
    assert (tb_mem_model_inst.bd_mem[2*idx] == exp)
      else report_mismatch($sformatf("tx status write-back at index %0d", idx));
    @(posedge clk_i);
    tx_ready_i <= 1'b1;
  endtask

  // Bus-level checks on every cycle
  always @(posedge clk_i) begin
    if (!arst_i) begin
      // With both engines waiting, the one not served last takes the port
      if (eth_dma_inst.tx_req && eth_dma_inst.rx_req && served_any) begin
        assert (eth_dma_inst.rx_gnt != rx_served_last && eth_dma_inst.tx_gnt == rx_served_last)
          else report_mismatch("round-robin grant");
      end
      if (eth_dma_inst.tx_gnt) begin
        rx_served_last = 1'b0;
        served_any = 1'b1;
      end else if (eth_dma_inst.rx_gnt) begin
        rx_served_last = 1'b1;
        served_any = 1'b1;
      end
      assert (axi_bready_o) else report_mismatch("bready low");
      assert (tx_en_i || !axi_arvalid_o) else report_mismatch("arvalid while disabled");
      assert (rx_en_i || !axi_awvalid_o) else report_mismatch("awvalid while disabled");
      assert (!axi_arvalid_o || axi_arlen_o < AXI_MAX_BURST_LEN) else report_mismatch("arlen");
      if (axi_awvalid_o && axi_awready_i) begin
        assert (axi_awlen_o < AXI_MAX_BURST_LEN) else report_mismatch("awlen");
        aw_cur = axi_awaddr_o;
        aw_len = axi_awlen_o;
        beat_n = 0;
      end
      if (axi_wvalid_o && axi_wready_i) begin
        assert (axi_wstrb_o == (4'b0001 << aw_cur[1:0])) else report_mismatch("wstrb lane");
        assert (axi_wlast_o == (beat_n == aw_len)) else report_mismatch("wlast position");
        beat_n++;
        aw_cur++;
        assert (beat_n <= AXI_MAX_BURST_LEN) else report_mismatch("burst too long");
      end
      // Old status word is still in memory during the write-back cycle
      if (bd_wen_o && bd_addr_o < 2 * RX_IDX) begin
        tx_wb_cnt++;
        assert (tx_irq_o == tb_mem_model_inst.bd_mem[bd_addr_o][BD_IRQ_BIT])
          else report_mismatch("tx_irq_o at write-back");
      end else if (bd_wen_o) begin
        rx_wb_cnt++;
        assert (rx_irq_o == tb_mem_model_inst.bd_mem[bd_addr_o][BD_IRQ_BIT])
          else report_mismatch("rx_irq_o at write-back");
      end
      assert (bd_wen_o || !(tx_irq_o || rx_irq_o)) else report_mismatch("stray interrupt");
      if (tx_irq_o) tx_irq_cnt++;
      if (rx_irq_o) rx_irq_cnt++;
    end
  end

  initial begin
    bd_word_t st0;
    bd_word_t st1;
    bd_word_t st2;
    bd_word_t rx_st;
    bd_word_t rx_exp;
    int       len0;
    int       len1;
    int       len2;
    int       rx_len;
    int       p0;
    int       p1;
    int       p2;
    int       pr;
    bit       crc_err;
    seed = 32'h9ff74d9e;
    error_count = 0;
    tx_wb_cnt = 0;
    rx_wb_cnt = 0;
    tx_irq_cnt = 0;
    rx_irq_cnt = 0;
    beat_n = 0;
    aw_cur = '0;
    aw_len = '0;
    rx_served_last = 1'b0;
    served_any = 1'b0;
    arst_i = 1'b1;
    tx_en_i = 1'b0;
    rx_en_i = 1'b0;
    tx_bd_num_i = bd_num_t'(RX_IDX);
    tx_ready_i = 1'b1;
    rx_data_rcvd_i = 1'b0;
    rx_nbytes_i = '0;
    crc_err_i = 1'b0;
    for (int i = 0; i < 256; i++) tb_mem_model_inst.bd_mem[i] = '0;

    len0 = 1 + ($unsigned($random(seed)) % 40);
    len1 = 17 + ($unsigned($random(seed)) % 24);
    len2 = 1 + ($unsigned($random(seed)) % 40);
    rx_len = 17 + ($unsigned($random(seed)) % 24);
    p0 = 32'h100 + ($unsigned($random(seed)) % 16);
    p1 = 32'h200 + ($unsigned($random(seed)) % 16);
    p2 = 32'h300 + ($unsigned($random(seed)) % 16);
    pr = 32'h800 + ($unsigned($random(seed)) % 16);
    crc_err = $random(seed);
    st0 = make_status(len0, 1'b1, 1'b0, $random(seed));
    st1 = make_status(len1, 1'b0, 1'b1, $random(seed));
    st2 = make_status(len2, 1'b0, 1'b0, $random(seed));
    rx_st = make_status(0, 1'b1, 1'b1, 1'b0);

    repeat (5) @(posedge clk_i);
    arst_i <= 1'b0;
    load_descriptor(0, st0, p0);
    load_descriptor(1, st1, p1);
    load_descriptor(RX_IDX, rx_st, pr);
    repeat (PRE_FRAME_LEN + 2) @(posedge clk_i);
    for (int i = 0; i < PREAMBLE_LEN; i++) begin
      assert (tb_mem_model_inst.tx_buf[i] == PREAMBLE_BYTE) else report_mismatch("preamble");
    end
    assert (tb_mem_model_inst.tx_buf[PREAMBLE_LEN] == SFD_BYTE) else report_mismatch("SFD");

    // Ready descriptors and a waiting frame stay untouched while both engines are disabled
    rx_nbytes_i <= frame_len_t'(rx_len);
    crc_err_i <= crc_err;
    rx_data_rcvd_i <= 1'b1;
    repeat (50) @(posedge clk_i);
    tx_en_i <= 1'b1;
    rx_en_i <= 1'b1;

    fork
      begin
        check_tx_frame(0, len0, p0, st0, 1);
        check_tx_frame(1, len1, p1, st1, 2);
        load_descriptor(0, st2, p2);
        check_tx_frame(0, len2, p2, st2, 3);
      end
      begin
        wait_for_ack();
        for (int i = 0; i < rx_len; i++) begin
          assert (tb_mem_model_inst.ext_mem[(pr + i) % 4096] == tb_mem_model_inst.rx_buf[i])
            else report_mismatch($sformatf("rx memory byte %0d", i));
        end
        @(posedge clk_i);
        rx_data_rcvd_i <= 1'b0;
        wait_for_writeback(1'b1, 1);
        rx_exp = rx_st;
        rx_exp[BD_READY_BIT] = 1'b0;
        rx_exp[BD_CRC_ERR_BIT] = crc_err;
        rx_exp[BD_LEN_MSB:BD_LEN_LSB] = 16'(rx_len);
        assert (tb_mem_model_inst.bd_mem[2*RX_IDX] == rx_exp)
          else report_mismatch("rx status write-back");
      end
    join

    repeat (4) @(posedge clk_i);
    assert (tx_irq_cnt == 1) else report_mismatch("tx interrupt count");
    assert (rx_irq_cnt == 1) else report_mismatch("rx interrupt count");
    if (error_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Verification failed");
      $fatal(1);
    end
  end

endmodule

//--- all.f
rtl/eth_dma_pkg.sv
rtl/bd_arbiter.sv
rtl/tx_dma.sv
rtl/rx_dma.sv
rtl/eth_dma.sv
test/tb_mem_model.sv
test/tb_eth_dma.sv
